// ==== vlog.f ====
+incdir+.
n2r_pkg.sv
ram_1w2r.sv
n2r_fill_ctrl.sv
n2r_slice_ctrl.sv
n2r_buffer_w.sv
tb_clkgen.sv
n2r_chk.sv
n2r_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the reorder buffer testbench with Verilator

verilator --binary --timing --assert -f vlog.f --top-module n2r_tb -o n2r_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/n2r_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification passed" sim.log; then
    exit 0
fi
exit 1

// ==== n2r_tb.sv ====
// ==========================================================================
// Testbench for the weight reorder buffer
// Random matrices in, 2x2 blocks compared against a reference model
// ==========================================================================
`timescale 1ns/1ns
`include "n2r_defines.svh"

module n2r_tb;

    localparam int TOTAL = `N2R_PAIRS * `N2R_CGRPS;

    logic            clk;
    logic            rst_n;
    logic            en;
    n2r_pkg::row_t   row_in;
    n2r_pkg::block_t block_out;
    logic            output_ready;
    logic            slice_done;
    logic            buffer_done;

    n2r_pkg::row_t matrix [`N2R_ROWS];
    logic [31:0]   lfsr = 32'h1c941248;
    int   err_cnt = 0;
    int   test_err0 = 0;
    int   tests_run = 0;
    int   tests_failed = 0;
    bit   timed_out = 1'b0;
    bit   ended = 1'b0;
    // Running totals kept by the comparing process
    int   blk_cnt = 0;
    int   ready_runs = 0;
    int   slice_cnt = 0;
    int   slice_blk = 0;
    int   bd_follows = 0;
    logic prev_ready = 1'b0;
    logic prev_slice = 1'b0;

    tb_clkgen u_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    n2r_buffer_w u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .row_in       (row_in),
        .block_out    (block_out),
        .output_ready (output_ready),
        .slice_done   (slice_done),
        .buffer_done  (buffer_done)
    );

    // Galois LFSR with taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] bits;
        int i;
        bits = '0;
        for (i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return bits;
    endfunction

    function automatic n2r_pkg::row_t random_row();
        n2r_pkg::row_t row;
        int c;
        row = '0;
        for (c = 0; c < `N2R_COLS; c++) begin
            row = (row << `N2R_WIDTH) | n2r_pkg::row_t'(rand_bits(`N2R_WIDTH));
        end
        return row;
    endfunction

    // Column 0 is the top element of a row
    function automatic n2r_pkg::elem_t elem_of(input n2r_pkg::row_t row, input int col);
        return n2r_pkg::elem_t'(row >> ((`N2R_COLS - 1 - col) * `N2R_WIDTH));
    endfunction

    // Lanes from the top (2p,2c) (2p+1,2c) (2p,2c+1) (2p+1,2c+1)
    function automatic n2r_pkg::block_t expected_block(input n2r_pkg::row_t m [`N2R_ROWS],
                                                      input int p, input int c);
        n2r_pkg::row_t upper;
        n2r_pkg::row_t lower;
        upper = m[n2r_pkg::row_addr_t'(2 * p)];
        lower = m[n2r_pkg::row_addr_t'(2 * p + 1)];
        return {elem_of(upper, 2 * c), elem_of(lower, 2 * c),
                elem_of(upper, 2 * c + 1), elem_of(lower, 2 * c + 1)};
    endfunction

    task automatic check_block(input int idx, input n2r_pkg::block_t got,
                               input n2r_pkg::block_t exp);
        if (got !== exp) begin
            $display("Mismatch block_out (block %0d): got %h expected %h", idx, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic wait_done_level(input logic level, input int limit, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (buffer_done !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (buffer_done !== level) begin
            $display("Timeout: %s not seen within %0d cycles", what, limit);
            timed_out = 1'b1;
        end
    endtask

    // Optional random idle cycles before each row, with junk on row_in
    task automatic fill_matrix(input bit gaps);
        int i;
        int g;
        int idle;
        for (i = 0; i < `N2R_ROWS; i++) begin
            matrix[n2r_pkg::row_addr_t'(i)] = random_row();
            idle = gaps ? int'(rand_bits(2)) : 0;
            for (g = 0; g < idle; g++) begin
                @(posedge clk);
                en     <= 1'b0;
                row_in <= random_row();
            end
            @(posedge clk);
            en     <= 1'b1;
            row_in <= matrix[n2r_pkg::row_addr_t'(i)];
        end
        @(posedge clk);
        row_in <= random_row();
    endtask

    task automatic run_pass(input bit gaps);
        int blk_base;
        int run_base;
        int slice_base;
        blk_base   = blk_cnt;
        run_base   = ready_runs;
        slice_base = slice_cnt;
        fill_matrix(gaps);
        wait_done_level(1'b1, 60, "buffer_done");
        if (!timed_out) begin
            @(posedge clk);
            check_count("blocks per pass", blk_cnt - blk_base, TOTAL);
            check_count("output_ready bursts", ready_runs - run_base, 1);
            check_count("slice_done pulses", slice_cnt - slice_base, 1);
            check_count("block at slice_done", slice_blk - blk_base, TOTAL);
            check_count("buffer_done after slice_done", bd_follows, slice_cnt);
        end
    endtask

    task automatic release_buffer();
        @(posedge clk);
        en <= 1'b0;
        wait_done_level(1'b0, 10, "buffer_done release");
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_cnt == test_err0 && !timed_out) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: FAILED with %0d errors", tests_run, name,
                     err_cnt - test_err0);
        end
        test_err0 = err_cnt;
    endtask

    // Compares every block as it leaves the DUT
    always @(negedge clk) begin
        int idx;
        if (rst_n) begin
            idx = blk_cnt % TOTAL;
            if (output_ready) begin
                check_block(idx, block_out,
                            expected_block(matrix, idx % `N2R_PAIRS, idx / `N2R_PAIRS));
                check_flag("slice_done", slice_done, logic'(idx == TOTAL - 1));
                blk_cnt++;
                if (!prev_ready) begin
                    ready_runs++;
                end
            end else if (slice_done) begin
                $display("Error: slice_done is high while output_ready is low");
                err_cnt++;
            end
            if (slice_done) begin
                slice_cnt++;
                slice_blk = blk_cnt;
            end
            if (prev_slice && buffer_done) begin
                bd_follows++;
            end
            prev_ready = output_ready;
            prev_slice = slice_done;
        end
    end

    initial begin
        int n;
        en     <= 1'b0;
        row_in <= '0;
        n = 0;
        while (rst_n !== 1'b1 && n < 40) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("Timeout: reset was never released");
            timed_out = 1'b1;
        end
        if (!timed_out) begin
            for (n = 0; n < 20; n++) begin
                @(negedge clk);
                check_flag("output_ready", output_ready, 1'b0);
                check_flag("slice_done", slice_done, 1'b0);
                check_flag("buffer_done", buffer_done, 1'b0);
            end
            end_test("idle after reset");
        end
        if (!timed_out) begin
            run_pass(1'b0);
            end_test("back-to-back rows");
        end
        if (!timed_out) begin
            // en stays high, so DONE must hold
            for (n = 0; n < 6; n++) begin
                @(negedge clk);
                check_flag("buffer_done", buffer_done, 1'b1);
            end
            release_buffer();
            end_test("done hold and release");
        end
        if (!timed_out) begin
            run_pass(1'b1);
            end_test("rows with en gaps");
        end
        if (!timed_out) begin
            release_buffer();
            if (!timed_out) begin
                run_pass(1'b0);
            end
            end_test("new matrix after release");
        end
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        ended = 1'b1;
        if (timed_out || err_cnt != 0) begin
            $display("Verification failed");
        end else begin
            $display("Verification passed");
        end
        $finish;
    end

    // Run stopped early, for example by an assertion
    final begin
        if (!ended) begin
            $display("Verification failed");
        end
    end

endmodule

// ==== n2r_chk.sv ====
// ==========================================================================
// Protocol checker for the reorder buffer control outputs
// ==========================================================================
`timescale 1ns/1ns

module n2r_chk (
    input logic             clk,
    input logic             rst_n,
    input logic             output_ready,
    input logic             slice_done,
    input logic             buffer_done,
    input logic             fill_done,
    input n2r_pkg::ram_wr_t ram_wr
);

    // No block leaves while rows are still being written
    a_ready_no_fill: assert property (@(posedge clk) disable iff (!rst_n)
        output_ready |-> !(fill_done || ram_wr.we))
        else $error("output_ready high during a row write or fill_done");

    a_slice_with_ready: assert property (@(posedge clk) disable iff (!rst_n)
        slice_done |-> output_ready)
        else $error("slice_done without output_ready");

    a_done_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
        !(buffer_done && output_ready))
        else $error("buffer_done and output_ready high together");

    // buffer_done comes exactly one cycle after the last block
    a_done_after_slice: assert property (@(posedge clk) disable iff (!rst_n)
        slice_done |=> buffer_done)
        else $error("buffer_done missing after slice_done");

    a_done_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(buffer_done) |-> $past(slice_done))
        else $error("buffer_done rose without slice_done");

endmodule

bind n2r_buffer_w n2r_chk u_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .output_ready (output_ready),
    .slice_done   (slice_done),
    .buffer_done  (buffer_done),
    .fill_done    (fill_done),
    .ram_wr       (ram_wr)
);

// ==== tb_clkgen.sv ====
// ==========================================================================
// Testbench clock (40 ns) and synchronous reset generator
// ==========================================================================
`timescale 1ns/1ns

module tb_clkgen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset held low for 16 rising edges
    initial begin
        rst_n <= 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== n2r_buffer_w.sv ====
// ==========================================================================
// Weight matrix reorder buffer
// Takes the matrix row by row and emits it as 2x2 vertical blocks
// ==========================================================================
`timescale 1ns/1ns

module n2r_buffer_w (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             en,
    input  n2r_pkg::row_t    row_in,
    output n2r_pkg::block_t  block_out,
    output logic             output_ready,
    output logic             slice_done,
    output logic             buffer_done
);

    n2r_pkg::ram_wr_t ram_wr;
    n2r_pkg::ram_rd_t rd_req;
    n2r_pkg::row_t    rd_data0;
    n2r_pkg::row_t    rd_data1;
    logic             fill_done;

    // Producer
    n2r_fill_ctrl u_fill (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .row_in      (row_in),
        .buffer_done (buffer_done),
        .ram_wr      (ram_wr),
        .fill_done   (fill_done)
    );

    ram_1w2r u_ram (
        .clk      (clk),
        .ram_wr   (ram_wr),
        .rd_req   (rd_req),
        .rd_data0 (rd_data0),
        .rd_data1 (rd_data1)
    );

    // Consumer
    n2r_slice_ctrl u_slice (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .fill_done    (fill_done),
        .rd_req       (rd_req),
        .rd_data0     (rd_data0),
        .rd_data1     (rd_data1),
        .block_out    (block_out),
        .output_ready (output_ready),
        .slice_done   (slice_done),
        .buffer_done  (buffer_done)
    );

endmodule

// ==== n2r_slice_ctrl.sv ====
// ==========================================================================
// Slice controller
// Walks the block indices, reads row pairs and assembles 2x2 blocks
// ==========================================================================
`timescale 1ns/1ns
`include "n2r_defines.svh"

module n2r_slice_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              en,
    input  logic              fill_done,
    output n2r_pkg::ram_rd_t  rd_req,
    input  n2r_pkg::row_t     rd_data0,
    input  n2r_pkg::row_t     rd_data1,
    output n2r_pkg::block_t   block_out,
    output logic              output_ready,
    output logic              slice_done,
    output logic              buffer_done
);

    n2r_pkg::slice_state_t state;
    n2r_pkg::slice_state_t state_next;

    n2r_pkg::pair_idx_t pair_idx;
    n2r_pkg::cgrp_idx_t cgrp_idx;
    n2r_pkg::cgrp_idx_t cgrp_d;
    n2r_pkg::block_t    blk_next;
    logic               slicing;
    logic               last_pair;
    logic               last_idx;
    logic               rd_vld;
    logic               rd_last;

    // Element of one column from a row, column 0 at the top
    function automatic n2r_pkg::elem_t elem_at(input n2r_pkg::row_t row, input int col);
        return row[(`N2R_COLS - 1 - col) * `N2R_WIDTH +: `N2R_WIDTH];
    endfunction

    assign slicing   = (state == n2r_pkg::S_SLICE);
    assign last_pair = (pair_idx == n2r_pkg::pair_idx_t'(`N2R_PAIRS - 1));
    assign last_idx  = last_pair && (cgrp_idx == n2r_pkg::cgrp_idx_t'(`N2R_CGRPS - 1));

    always_comb begin
        state_next = state;
        case (state)
            n2r_pkg::S_IDLE:  if (fill_done) state_next = n2r_pkg::S_SLICE;
            n2r_pkg::S_SLICE: if (last_idx) state_next = n2r_pkg::S_DRAIN;
            // Last block leaves with slice_done
            n2r_pkg::S_DRAIN: if (slice_done) state_next = n2r_pkg::S_DONE;
            n2r_pkg::S_DONE:  if (!en) state_next = n2r_pkg::S_IDLE;
            default:          state_next = n2r_pkg::S_IDLE;
        endcase
    end

    // Row pair is the inner index, column group the outer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= n2r_pkg::S_IDLE;
            pair_idx <= '0;
            cgrp_idx <= '0;
        end else begin
            state <= state_next;
            if (slicing) begin
                pair_idx <= last_pair ? '0 : pair_idx + 1'b1;
                if (last_pair) begin
                    cgrp_idx <= (cgrp_idx == n2r_pkg::cgrp_idx_t'(`N2R_CGRPS - 1)) ?
                                '0 : cgrp_idx + 1'b1;
                end
            end
        end
    end

    // Rows 2p and 2p+1
    assign rd_req = '{
        addr0: n2r_pkg::row_addr_t'(`N2R_BLK * pair_idx),
        addr1: n2r_pkg::row_addr_t'(`N2R_BLK * pair_idx + 1)
    };

    // Read stage, aligned with the RAM output
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_vld  <= 1'b0;
            rd_last <= 1'b0;
            cgrp_d  <= '0;
        end else begin
            rd_vld  <= slicing;
            rd_last <= slicing && last_idx;
            cgrp_d  <= cgrp_idx;
        end
    end

    // Columns 2c and 2c+1 from both rows, interleaved by row
    always_comb begin
        int col;
        blk_next = '0;
        for (int j = 0; j < `N2R_BLK; j++) begin
            col = int'(cgrp_d) * `N2R_BLK + j;
            blk_next[(`N2R_BLK*`N2R_BLK - 1 - j*`N2R_BLK) * `N2R_WIDTH +: `N2R_WIDTH] =
                elem_at(rd_data0, col);
            blk_next[(`N2R_BLK*`N2R_BLK - 2 - j*`N2R_BLK) * `N2R_WIDTH +: `N2R_WIDTH] =
                elem_at(rd_data1, col);
        end
    end

    // Output stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            output_ready <= 1'b0;
            slice_done   <= 1'b0;
        end else begin
            output_ready <= rd_vld;
            slice_done   <= rd_vld && rd_last;
        end
    end

    always_ff @(posedge clk) begin
        block_out <= blk_next;
    end

    assign buffer_done = (state == n2r_pkg::S_DONE);

endmodule

// ==== n2r_fill_ctrl.sv ====
// ==========================================================================
// Fill controller
// Registers incoming rows, counts them and drives the RAM write port
// ==========================================================================
`timescale 1ns/1ns
`include "n2r_defines.svh"

module n2r_fill_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              en,
    input  n2r_pkg::row_t     row_in,
    input  logic              buffer_done,
    output n2r_pkg::ram_wr_t  ram_wr,
    output logic              fill_done
);

    n2r_pkg::fill_state_t state;
    n2r_pkg::fill_state_t state_next;

    n2r_pkg::row_addr_t row_cnt;
    n2r_pkg::row_addr_t wr_addr;
    n2r_pkg::row_t      wr_data;
    logic               wr_we;
    logic               capture;
    logic               last_row;

    // A row is taken whenever en is high before the buffer is full
    assign capture  = en && (state == n2r_pkg::F_IDLE || state == n2r_pkg::F_FILL);
    assign last_row = (row_cnt == n2r_pkg::row_addr_t'(`N2R_ROWS - 1));

    always_comb begin
        state_next = state;
        case (state)
            n2r_pkg::F_IDLE: begin
                if (en) begin
                    state_next = n2r_pkg::F_FILL;
                end
            end
            n2r_pkg::F_FILL: begin
                if (capture && last_row) begin
                    state_next = n2r_pkg::F_FULL;
                end
            end
            n2r_pkg::F_FULL: begin
                // Wait for the slice pass to finish and en to drop
                if (buffer_done && !en) begin
                    state_next = n2r_pkg::F_IDLE;
                end
            end
            default: state_next = n2r_pkg::F_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= n2r_pkg::F_IDLE;
            row_cnt   <= '0;
            wr_we     <= 1'b0;
            fill_done <= 1'b0;
        end else begin
            state     <= state_next;
            wr_we     <= capture;
            fill_done <= capture && last_row;
            if (capture) begin
                row_cnt <= last_row ? '0 : row_cnt + 1'b1;
            end
        end
    end

    // Input register for the row and its address
    always_ff @(posedge clk) begin
        if (capture) begin
            wr_addr <= row_cnt;
            wr_data <= row_in;
        end
    end

    assign ram_wr = '{we: wr_we, addr: wr_addr, data: wr_data};

endmodule

// ==== ram_1w2r.sv ====
// ==========================================================================
// Row memory with one write port and two registered read ports
// ==========================================================================
`timescale 1ns/1ns
`include "n2r_defines.svh"

module ram_1w2r (
    input  logic              clk,
    input  n2r_pkg::ram_wr_t  ram_wr,
    input  n2r_pkg::ram_rd_t  rd_req,
    output n2r_pkg::row_t     rd_data0,
    output n2r_pkg::row_t     rd_data1
);

    // One whole matrix row per word
    n2r_pkg::row_t mem [`N2R_ROWS];

    always_ff @(posedge clk) begin
        if (ram_wr.we) begin
            mem[ram_wr.addr] <= ram_wr.data;
        end
    end

    // Both reads see the contents from before a same-cycle write
    always_ff @(posedge clk) begin
        rd_data0 <= mem[rd_req.addr0];
        rd_data1 <= mem[rd_req.addr1];
    end

endmodule

// ==== n2r_pkg.sv ====
// ==========================================================================
// Weight reorder buffer types
// Element, row, block and index types, RAM port structs and FSM states
// ==========================================================================
`include "n2r_defines.svh"

package n2r_pkg;

    typedef logic [`N2R_WIDTH-1:0] elem_t;

    // Column 0 sits in the most significant element
    typedef logic [`N2R_COLS*`N2R_WIDTH-1:0] row_t;

    // Lanes from the top: (2p,2c) (2p+1,2c) (2p,2c+1) (2p+1,2c+1)
    typedef logic [`N2R_BLK*`N2R_BLK*`N2R_WIDTH-1:0] block_t;

    typedef logic [$clog2(`N2R_ROWS)-1:0] row_addr_t;
    typedef logic [$clog2(`N2R_PAIRS)-1:0] pair_idx_t;
    typedef logic [$clog2(`N2R_CGRPS)-1:0] cgrp_idx_t;

    typedef enum logic [1:0] {
        F_IDLE,
        F_FILL,
        F_FULL
    } fill_state_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_SLICE,
        S_DRAIN,
        S_DONE
    } slice_state_t;

    // RAM write port
    typedef struct packed {
        logic      we;
        row_addr_t addr;
        row_t      data;
    } ram_wr_t;

    // Row pair read request
    typedef struct packed {
        row_addr_t addr0;
        row_addr_t addr1;
    } ram_rd_t;

endpackage

// ==== n2r_defines.svh ====
// ==========================================================================
// Weight reorder buffer sizes
// Matrix geometry and block shape shared by the package and the RTL
// ==========================================================================
`ifndef N2R_DEFINES_SVH
`define N2R_DEFINES_SVH

// Bits per matrix element
`define N2R_WIDTH 16

// Weight matrix geometry, kept small for short simulations
`define N2R_ROWS 8
`define N2R_COLS 4

// Rows and columns per output block
`define N2R_BLK 2

// Derived counts
`define N2R_PAIRS (`N2R_ROWS / `N2R_BLK)
`define N2R_CGRPS (`N2R_COLS / `N2R_BLK)

`endif
